//--- if_id_stage_tmr.f
design/if_id_pkg.sv
design/tmr_pkg.sv
design/replica_bus_if.sv
design/if_id_stage.sv
design/tmr_voter.sv
design/breakage_monitor.sv
design/if_id_stage_tmr.sv
test/tb_if_id_stage_tmr.sv

//--- test/tb_if_id_stage_tmr.sv
// Testbench for the fault-tolerant IF/ID stage
// Directed tests for normal flow, voted data and stage-valid faults,
// and replica retirement by count and by force

`timescale 1ns/10ps

module tb_if_id_stage_tmr;

        import if_id_pkg::*;
        import tmr_pkg::*;

        localparam logic [31:0] LFSR_SEED = 32'h3c920d10;
        // x^32 + x^30 + x^26 + x^25 + 1
        localparam logic [31:0] LFSR_TAPS = 32'ha3000000;
        localparam int          BROKEN_TIMEOUT = 10;

        logic clk;
        logic rst;

        // Per-replica stimulus
        logic [NUM_REPLICAS-1:0][XLEN-1:0] instr_decompressed;
        logic [NUM_REPLICAS-1:0]           instr_compressed;
        logic [NUM_REPLICAS-1:0][XLEN-1:0] pc_if;
        logic [NUM_REPLICAS-1:0]           fetch_failed;
        logic [NUM_REPLICAS-1:0]           illegal_c_insn;
        logic [NUM_REPLICAS-1:0]           fetch_valid;
        logic [NUM_REPLICAS-1:0]           id_ready;
        logic [NUM_REPLICAS-1:0]           halt_if;
        logic [NUM_REPLICAS-1:0]           clear_instr_valid;
        replica_mask_t                     set_broken;

        // DUT responses
        logic            instr_valid_id;
        logic [XLEN-1:0] instr_rdata_id;
        logic [XLEN-1:0] pc_id;
        logic            is_compressed_id;
        logic            illegal_c_insn_id;
        logic            is_fetch_failed;
        logic            if_valid;
        replica_mask_t   is_broken;
        logic            err_detected;
        logic            err_corrected;

        logic [31:0] lfsr_state;
        int          check_count;
        int          error_count;
        int          test_count;
        int          failed_tests;

        if_id_stage_tmr i_dut (
                .clk                  (clk),
                .rst_i                (rst),
                .instr_decompressed_i (instr_decompressed),
                .instr_compressed_i   (instr_compressed),
                .pc_if_i              (pc_if),
                .fetch_failed_i       (fetch_failed),
                .illegal_c_insn_i     (illegal_c_insn),
                .fetch_valid_i        (fetch_valid),
                .id_ready_i           (id_ready),
                .halt_if_i            (halt_if),
                .clear_instr_valid_i  (clear_instr_valid),
                .set_broken_i         (set_broken),
                .instr_valid_id_o     (instr_valid_id),
                .instr_rdata_id_o     (instr_rdata_id),
                .pc_id_o              (pc_id),
                .is_compressed_id_o   (is_compressed_id),
                .illegal_c_insn_id_o  (illegal_c_insn_id),
                .is_fetch_failed_o    (is_fetch_failed),
                .if_valid_o           (if_valid),
                .is_broken_o          (is_broken),
                .err_detected_o       (err_detected),
                .err_corrected_o      (err_corrected)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        ////////////////////////////////////////
        // Random numbers
        ////////////////////////////////////////

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ LFSR_TAPS;
                end
                return s >> 1;
        endfunction

        // One LFSR step per bit taken
        task automatic random_bits(input int n, output logic [31:0] value);
                value = '0;
                for (int i = 0; i < n; i++) begin
                        value      = {value[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_next(lfsr_state);
                end
        endtask

        ////////////////////////////////////////
        // Checks
        ////////////////////////////////////////

        task automatic compare_entry(input id_entry_t actual, input id_entry_t expected,
                                     input string msg);
                check_count++;
                if (actual !== expected) begin
                        error_count++;
                        $display("MISMATCH at %0t ns: %s, got %h expected %h",
                                 $time, msg, actual, expected);
                end
        endtask

        task automatic compare_mask(input replica_mask_t actual, input replica_mask_t expected,
                                    input string msg);
                check_count++;
                if (actual !== expected) begin
                        error_count++;
                        $display("MISMATCH at %0t ns: %s, got %b expected %b",
                                 $time, msg, actual, expected);
                end
        endtask

        task automatic compare_bit(input logic actual, input logic expected, input string msg);
                check_count++;
                if (actual !== expected) begin
                        error_count++;
                        $display("MISMATCH at %0t ns: %s, got %b expected %b",
                                 $time, msg, actual, expected);
                end
        endtask

        function automatic id_entry_t make_entry(input logic valid, input logic [31:0] instr,
                                                 input logic [31:0] pc, input logic [2:0] flags);
                id_entry_t e;
                e.instr_valid    = valid;
                e.instr_rdata    = instr;
                e.pc             = pc;
                e.is_compressed  = flags[0];
                e.illegal_c_insn = flags[1];
                e.fetch_failed   = flags[2];
                return e;
        endfunction

        function automatic id_entry_t outputs_as_entry();
                id_entry_t e;
                e.instr_valid    = instr_valid_id;
                e.instr_rdata    = instr_rdata_id;
                e.pc             = pc_id;
                e.is_compressed  = is_compressed_id;
                e.illegal_c_insn = illegal_c_insn_id;
                e.fetch_failed   = is_fetch_failed;
                return e;
        endfunction

        task automatic check_flags(input logic detected, input logic corrected, input string msg);
                compare_bit(err_detected, detected, {msg, ", err_detected"});
                compare_bit(err_corrected, corrected, {msg, ", err_corrected"});
        endtask

        ////////////////////////////////////////
        // Stimulus helpers
        ////////////////////////////////////////

        task automatic drive_idle();
                instr_decompressed = '0;
                instr_compressed   = '0;
                pc_if              = '0;
                fetch_failed       = '0;
                illegal_c_insn     = '0;
                fetch_valid        = '0;
                id_ready           = '1;
                halt_if            = '0;
                clear_instr_valid  = '0;
                set_broken         = '0;
        endtask

        // Same fetch on every replica, stage free to advance
        task automatic present_fetch(input logic [31:0] instr, input logic [31:0] pc,
                                     input logic [2:0] flags);
                instr_decompressed = {NUM_REPLICAS{instr}};
                pc_if              = {NUM_REPLICAS{pc}};
                instr_compressed   = {NUM_REPLICAS{flags[0]}};
                illegal_c_insn     = {NUM_REPLICAS{flags[1]}};
                fetch_failed       = {NUM_REPLICAS{flags[2]}};
                fetch_valid        = '1;
                id_ready           = '1;
                halt_if            = '0;
                clear_instr_valid  = '0;
        endtask

        // Registered outputs are read at the falling edge, new inputs go in there too
        task automatic next_cycle();
                @(posedge clk);
                @(negedge clk);
        endtask

        task automatic reset_dut();
                drive_idle();
                rst = 1'b1;
                repeat (4) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                compare_bit(instr_valid_id, 1'b0, "instr_valid_id_o after reset");
                compare_mask(is_broken, '0, "is_broken_o after reset");
        endtask

        task automatic wait_broken(input int idx);
                int cycles;
                cycles = 0;
                while (is_broken[idx] !== 1'b1 && cycles < BROKEN_TIMEOUT) begin
                        next_cycle();
                        cycles++;
                end
                if (is_broken[idx] !== 1'b1) begin
                        error_count++;
                        $display("Timeout: replica %0d was not retired within %0d cycles",
                                 idx, BROKEN_TIMEOUT);
                end
        endtask

        task automatic finish_test(input string name, input int errors_before);
                test_count++;
                if (error_count == errors_before) begin
                        $display("Test %s: ok", name);
                end else begin
                        failed_tests++;
                        $display("Test %s: %0d errors", name, error_count - errors_before);
                end
        endtask

        ////////////////////////////////////////
        // Tests
        ////////////////////////////////////////

        task automatic test_normal_flow();
                int          errors_before;
                logic [31:0] instr;
                logic [31:0] pc;
                logic [31:0] flags;
                id_entry_t   expected;
                errors_before = error_count;
                reset_dut();
                for (int n = 0; n < 4; n++) begin
                        random_bits(32, instr);
                        random_bits(32, pc);
                        random_bits(3, flags);
                        present_fetch(instr, pc, flags[2:0]);
                        expected = make_entry(1'b1, instr, pc, flags[2:0]);
                        #1;
                        compare_bit(if_valid, 1'b1, "if_valid_o on accepted fetch");
                        check_flags(1'b0, 1'b0, "accepted fetch");
                        next_cycle();
                        compare_entry(outputs_as_entry(), expected, "captured entry");
                end
                // Back-pressure, then halt, with new data waiting
                random_bits(32, instr);
                present_fetch(instr, pc, 3'b000);
                id_ready = '0;
                for (int n = 0; n < 3; n++) begin
                        if (n == 2) begin
                                id_ready = '1;
                                halt_if  = '1;
                        end
                        #1;
                        compare_bit(if_valid, 1'b0, "if_valid_o while stalled");
                        check_flags(1'b0, 1'b0, "stall");
                        next_cycle();
                        compare_entry(outputs_as_entry(), expected, "entry held while stalled");
                end
                drive_idle();
                clear_instr_valid = '1;
                #1;
                compare_bit(if_valid, 1'b0, "if_valid_o during clear");
                next_cycle();
                expected.instr_valid = 1'b0;
                compare_entry(outputs_as_entry(), expected, "entry after clear");
                check_flags(1'b0, 1'b0, "after clear");
                finish_test("normal_flow", errors_before);
        endtask

        task automatic test_corrected_data();
                int          errors_before;
                logic [31:0] instr;
                logic [31:0] pc;
                id_entry_t   expected;
                errors_before = error_count;
                reset_dut();
                random_bits(32, instr);
                random_bits(32, pc);
                present_fetch(instr, pc, 3'b001);
                instr_decompressed[2] = ~instr;
                expected = make_entry(1'b1, instr, pc, 3'b001);
                next_cycle();
                fetch_valid = '0;
                for (int n = 0; n < 2; n++) begin
                        #1;
                        compare_entry(outputs_as_entry(), expected, "majority entry");
                        check_flags(1'b1, 1'b1, "replica 2 data fault");
                        compare_mask(is_broken, '0, "no replica retired yet");
                        next_cycle();
                end
                finish_test("corrected_data", errors_before);
        endtask

        task automatic test_stage_valid_fault();
                int          errors_before;
                logic [31:0] instr;
                logic [31:0] pc;
                errors_before = error_count;
                reset_dut();
                random_bits(32, instr);
                random_bits(32, pc);
                present_fetch(instr, pc, 3'b000);
                halt_if = 3'b010;
                #1;
                compare_bit(if_valid, 1'b1, "if_valid_o with replica 1 halted");
                check_flags(1'b1, 1'b1, "halt on replica 1");
                next_cycle();
                compare_entry(outputs_as_entry(), make_entry(1'b1, instr, pc, 3'b000),
                              "entry after partial capture");
                // Only replica 2 sees a fetch, the majority says no
                halt_if     = '0;
                fetch_valid = 3'b100;
                #1;
                compare_bit(if_valid, 1'b0, "if_valid_o with two replicas idle");
                check_flags(1'b1, 1'b1, "lone fetch_valid");
                finish_test("stage_valid_fault", errors_before);
        endtask

        task automatic test_breakage_by_count();
                int          errors_before;
                logic [31:0] instr;
                logic [31:0] pc;
                id_entry_t   expected;
                errors_before = error_count;
                reset_dut();
                random_bits(32, instr);
                random_bits(32, pc);
                present_fetch(instr, pc, 3'b100);
                pc_if[0] = pc ^ 32'h0000_0004;
                expected = make_entry(1'b1, instr, pc, 3'b100);
                next_cycle();
                id_ready = '0;
                for (int n = 1; n <= 4; n++) begin
                        #1;
                        compare_entry(outputs_as_entry(), expected,
                                      "majority entry with replica 0 corrupted");
                        check_flags(1'b1, 1'b1, "held fault in replica 0");
                        next_cycle();
                        compare_mask(is_broken, (n == 4) ? 3'b001 : 3'b000,
                                     $sformatf("is_broken_o after %0d error cycles", n));
                end
                #1;
                check_flags(1'b0, 1'b0, "replica 0 retired");
                compare_entry(outputs_as_entry(), expected, "entry with replica 0 retired");
                finish_test("breakage_by_count", errors_before);
        endtask

        task automatic test_forced_breakage();
                int          errors_before;
                logic [31:0] instr;
                logic [31:0] pc;
                errors_before = error_count;
                reset_dut();
                set_broken = 3'b010;
                next_cycle();
                set_broken = '0;
                wait_broken(1);
                compare_mask(is_broken, 3'b010, "is_broken_o after forced retirement");
                random_bits(32, instr);
                random_bits(32, pc);
                present_fetch(instr, pc, 3'b010);
                instr_decompressed[2] = instr ^ 32'h8000_0001;
                // Retired replica sides with replica 2, so a plain majority would pick the wrong value
                instr_decompressed[1] = instr ^ 32'h8000_0001;
                next_cycle();
                fetch_valid = '0;
                #1;
                compare_entry(outputs_as_entry(), make_entry(1'b1, instr, pc, 3'b010),
                              "entry taken from replica 0");
                check_flags(1'b1, 1'b0, "two healthy replicas disagree");
                finish_test("forced_breakage", errors_before);
        endtask

        initial begin
                lfsr_state   = LFSR_SEED;
                check_count  = 0;
                error_count  = 0;
                test_count   = 0;
                failed_tests = 0;
                rst          = 1'b1;
                drive_idle();

                test_normal_flow();
                test_corrected_data();
                test_stage_valid_fault();
                test_breakage_by_count();
                test_forced_breakage();

                $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                         test_count, failed_tests, check_count, error_count);
                if (error_count == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule

//--- design/if_id_stage_tmr.sv
// Fault-tolerant IF/ID stage
// Three independent IF/ID replicas voted into one result, with a
// breakage monitor per replica and error reporting to software

`timescale 1ns/10ps

module if_id_stage_tmr (
        input  logic                                                 clk,
        input  logic                                                 rst_i,

        // Fetch side, one element per replica
        input  logic [tmr_pkg::NUM_REPLICAS-1:0][if_id_pkg::XLEN-1:0] instr_decompressed_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      instr_compressed_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0][if_id_pkg::XLEN-1:0] pc_if_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      fetch_failed_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      illegal_c_insn_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      fetch_valid_i,

        // Decode side and controller, one element per replica
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      id_ready_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      halt_if_i,
        input  logic [tmr_pkg::NUM_REPLICAS-1:0]                      clear_instr_valid_i,

        // Forced retirement from software
        input  tmr_pkg::replica_mask_t                                set_broken_i,

        // Voted entry towards decode
        output logic                                                 instr_valid_id_o,
        output logic [if_id_pkg::XLEN-1:0]                           instr_rdata_id_o,
        output logic [if_id_pkg::XLEN-1:0]                           pc_id_o,
        output logic                                                 is_compressed_id_o,
        output logic                                                 illegal_c_insn_id_o,
        output logic                                                 is_fetch_failed_o,
        output logic                                                 if_valid_o,

        // Fault status
        output tmr_pkg::replica_mask_t                                is_broken_o,
        output logic                                                 err_detected_o,
        output logic                                                 err_corrected_o
);

        import if_id_pkg::*;
        import tmr_pkg::*;

        replica_bus_if rbus ();

        id_entry_t     voted_entry;
        replica_mask_t entry_block_err;
        replica_mask_t valid_block_err;
        replica_mask_t replica_err;
        logic          entry_err_detected;
        logic          entry_err_corrected;
        logic          valid_err_detected;
        logic          valid_err_corrected;

        ////////////////////////////////////////
        // Replicas and their monitors
        ////////////////////////////////////////

        for (genvar g = 0; g < NUM_REPLICAS; g++) begin : g_replica
                if_id_stage i_stage (
                        .clk                  (clk),
                        .rst_i                (rst_i),
                        .instr_decompressed_i (instr_decompressed_i[g]),
                        .instr_compressed_i   (instr_compressed_i[g]),
                        .pc_if_i              (pc_if_i[g]),
                        .fetch_failed_i       (fetch_failed_i[g]),
                        .illegal_c_insn_i     (illegal_c_insn_i[g]),
                        .fetch_valid_i        (fetch_valid_i[g]),
                        .id_ready_i           (id_ready_i[g]),
                        .halt_if_i            (halt_if_i[g]),
                        .clear_instr_valid_i  (clear_instr_valid_i[g]),
                        .entry_o              (rbus.entry[g]),
                        .stage_valid_o        (rbus.stage_valid[g])
                );

                breakage_monitor i_monitor (
                        .clk            (clk),
                        .rst_i          (rst_i),
                        .err_detected_i (replica_err[g]),
                        .set_broken_i   (set_broken_i[g]),
                        .is_broken_o    (is_broken_o[g])
                );
        end

        ////////////////////////////////////////
        // Voters
        ////////////////////////////////////////

        // Registered entry, all fields in one go
        tmr_voter #(
                .payload_t (id_entry_t)
        ) i_entry_voter (
                .replica_i       (rbus.entry),
                .broken_i        (is_broken_o),
                .voted_o         (voted_entry),
                .block_err_o     (entry_block_err),
                .err_detected_o  (entry_err_detected),
                .err_corrected_o (entry_err_corrected)
        );

        // Combinational stage-valid, goes straight to if_valid_o
        tmr_voter #(
                .payload_t (logic)
        ) i_valid_voter (
                .replica_i       (rbus.stage_valid),
                .broken_i        (is_broken_o),
                .voted_o         (if_valid_o),
                .block_err_o     (valid_block_err),
                .err_detected_o  (valid_err_detected),
                .err_corrected_o (valid_err_corrected)
        );

        ////////////////////////////////////////
        // Error collection
        ////////////////////////////////////////

        // A replica is charged if it lost either vote
        assign replica_err = entry_block_err | valid_block_err;

        assign err_detected_o  = entry_err_detected | valid_err_detected;
        assign err_corrected_o = entry_err_corrected | valid_err_corrected;

        // Voted entry onto the decode ports
        assign instr_valid_id_o    = voted_entry.instr_valid;
        assign instr_rdata_id_o    = voted_entry.instr_rdata;
        assign pc_id_o             = voted_entry.pc;
        assign is_compressed_id_o  = voted_entry.is_compressed;
        assign illegal_c_insn_id_o = voted_entry.illegal_c_insn;
        assign is_fetch_failed_o   = voted_entry.fetch_failed;

endmodule

//--- design/breakage_monitor.sv
// Breakage monitor
// Leaky error counter for one replica; the replica is retired once
// the count reaches the threshold or software forces it out

`timescale 1ns/10ps

module breakage_monitor (
        input  logic clk,
        input  logic rst_i,
        input  logic err_detected_i,
        input  logic set_broken_i,
        output logic is_broken_o
);

        import tmr_pkg::*;

        logic [BRK_COUNT_BITS-1:0] count_q;
        logic [BRK_COUNT_BITS-1:0] count_d;
        logic [BRK_COUNT_BITS:0]   count_inc;
        logic                      broken_q;

        ////////////////////////////////////////
        // Next count
        ////////////////////////////////////////

        // One extra bit catches the overflow for saturation
        assign count_inc = {1'b0, count_q} + (BRK_COUNT_BITS + 1)'(BRK_INCREMENT);

        always_comb begin
                if (err_detected_i) begin
                        if (count_inc[BRK_COUNT_BITS]) begin
                                count_d = '1;
                        end else begin
                                count_d = count_inc[BRK_COUNT_BITS-1:0];
                        end
                end else if (count_q >= BRK_COUNT_BITS'(BRK_DECREMENT)) begin
                        count_d = count_q - BRK_COUNT_BITS'(BRK_DECREMENT);
                end else begin
                        count_d = '0;
                end
        end

        ////////////////////////////////////////
        // State
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        count_q  <= '0;
                        broken_q <= 1'b0;
                end else begin
                        count_q <= count_d;
                        // Sticky until reset
                        if (set_broken_i || (count_d >= BRK_COUNT_BITS'(BRK_THRESHOLD))) begin
                                broken_q <= 1'b1;
                        end
                end
        end

        assign is_broken_o = broken_q;

endmodule

//--- design/tmr_voter.sv
// Three-way majority voter
// Votes a payload of any packed type across the replicas, skips
// replicas already retired and flags the ones that disagree

`timescale 1ns/10ps

module tmr_voter #(
        parameter type payload_t = logic
) (
        input  payload_t [tmr_pkg::NUM_REPLICAS-1:0] replica_i,
        input  tmr_pkg::replica_mask_t                broken_i,
        output payload_t                              voted_o,
        output tmr_pkg::replica_mask_t                block_err_o,
        output logic                                  err_detected_o,
        output logic                                  err_corrected_o
);

        import tmr_pkg::*;

        // Payload seen as plain bits so any packed type can be voted
        logic [NUM_REPLICAS-1:0][$bits(payload_t)-1:0] rep;
        logic [$bits(payload_t)-1:0]                   majority;
        logic [$bits(payload_t)-1:0]                   voted_bits;
        replica_mask_t                                 block_err;

        assign rep = replica_i;

        // Bitwise two-out-of-three
        assign majority = (rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]);

        ////////////////////////////////////////
        // Selection and error marking
        ////////////////////////////////////////

        always_comb begin
                voted_bits = majority;
                block_err  = '0;

                if (broken_i == '0) begin
                        // All replicas healthy, flag whoever lost the vote
                        for (int i = 0; i < NUM_REPLICAS; i++) begin
                                block_err[i] = (rep[i] != majority);
                        end
                end else begin
                        // Walk downwards so the lowest healthy index wins
                        for (int i = NUM_REPLICAS - 1; i >= 0; i--) begin
                                if (!broken_i[i]) begin
                                        voted_bits = rep[i];
                                end
                        end

                        // No tie-breaker left, so both sides of a mismatch are suspect
                        for (int i = 0; i < NUM_REPLICAS; i++) begin
                                for (int j = 0; j < NUM_REPLICAS; j++) begin
                                        if (!broken_i[i] && !broken_i[j] &&
                                            (rep[i] != rep[j])) begin
                                                block_err[i] = 1'b1;
                                        end
                                end
                        end
                end
        end

        ////////////////////////////////////////
        // Outputs
        ////////////////////////////////////////

        assign voted_o     = payload_t'(voted_bits);
        assign block_err_o = block_err;

        assign err_detected_o = |block_err;

        // A single outvoted replica is only fixable with all three in play
        assign err_corrected_o = (broken_i == '0) && $onehot(block_err);

endmodule

//--- design/if_id_stage.sv
// IF/ID pipeline register, single replica
// Decides when the fetch side hands an instruction to decode and
// holds the fetched entry until decode takes the next one

`timescale 1ns/10ps

module if_id_stage (
        input  logic                       clk,
        input  logic                       rst_i,

        // Fetch side
        input  logic [if_id_pkg::XLEN-1:0] instr_decompressed_i,
        input  logic                       instr_compressed_i,
        input  logic [if_id_pkg::XLEN-1:0] pc_if_i,
        input  logic                       fetch_failed_i,
        input  logic                       illegal_c_insn_i,
        input  logic                       fetch_valid_i,

        // Decode side and controller
        input  logic                       id_ready_i,
        input  logic                       halt_if_i,
        input  logic                       clear_instr_valid_i,

        // Registered entry and stage-valid towards the voters
        output if_id_pkg::id_entry_t       entry_o,
        output logic                       stage_valid_o
);

        import if_id_pkg::*;

        id_entry_t entry_q;
        logic      stage_valid;

        ////////////////////////////////////////
        // Stage advance
        ////////////////////////////////////////

        // Fetch has data, decode can take it and nobody halts fetch
        assign stage_valid = fetch_valid_i & id_ready_i & ~halt_if_i;

        ////////////////////////////////////////
        // Entry register
        ////////////////////////////////////////

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        entry_q <= '0;
                end else if (stage_valid) begin
                        entry_q.instr_valid    <= 1'b1;
                        entry_q.instr_rdata    <= instr_decompressed_i;
                        entry_q.pc             <= pc_if_i;
                        entry_q.is_compressed  <= instr_compressed_i;
                        entry_q.illegal_c_insn <= illegal_c_insn_i;
                        entry_q.fetch_failed   <= fetch_failed_i;
                end else if (clear_instr_valid_i) begin
                        // Drop the instruction, keep the rest for debug visibility
                        entry_q.instr_valid <= 1'b0;
                end
        end

        // Under back-pressure nothing above fires and every field holds

        assign entry_o       = entry_q;
        assign stage_valid_o = stage_valid;

endmodule

//--- design/replica_bus_if.sv
// Replica bus
// Carries the registered entry and the stage-valid bit of every
// IF/ID replica towards the voters, sampled every cycle

`timescale 1ns/10ps

interface replica_bus_if;

        import if_id_pkg::*;
        import tmr_pkg::*;

        // Registered entry, one element per replica
        id_entry_t [NUM_REPLICAS-1:0] entry;

        // Combinational stage-valid bit, one per replica
        replica_mask_t stage_valid;

        ////////////////////////////////////////
        // Views
        ////////////////////////////////////////

        // Replica side, each stage drives only its own index
        modport stage (
                output entry,
                output stage_valid
        );

        // Voter side, read only
        modport vote (
                input entry,
                input stage_valid
        );

endinterface

//--- design/tmr_pkg.sv
// Triple modular redundancy definitions
// Replica count, the per-replica mask type and the tuning of the
// breakage monitors that retire faulty replicas

package tmr_pkg;

        // Number of redundant copies of the IF/ID register
        localparam int NUM_REPLICAS = 3;

        // One bit per replica
        typedef logic [NUM_REPLICAS-1:0] replica_mask_t;

        ////////////////////////////////////////
        // Breakage monitor tuning
        ////////////////////////////////////////

        // Width of each error counter
        localparam int BRK_COUNT_BITS = 4;

        // Added on a cycle where the replica disagreed
        localparam int BRK_INCREMENT = 2;

        // Taken off on a clean cycle
        localparam int BRK_DECREMENT = 1;

        // Count at which the replica is retired for good
        localparam int BRK_THRESHOLD = 8;

endpackage

//--- design/if_id_pkg.sv
// IF/ID stage definitions
// Datapath widths and the layout of one registered IF/ID entry,
// shared by every replica, the voters and the testbench

package if_id_pkg;

        // Instruction and address width
        localparam int XLEN = 32;

        ////////////////////////////////////////
        // Registered stage contents
        ////////////////////////////////////////

        // One entry as held between fetch and decode, 68 bits in total
        typedef struct packed {
                logic            instr_valid;
                logic [XLEN-1:0] instr_rdata;
                logic [XLEN-1:0] pc;
                logic            is_compressed;
                logic            illegal_c_insn;
                logic            fetch_failed;
        } id_entry_t;

endpackage
